// File: src/ooo_cfg.svh
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// data and address width
`define OOO_XLEN 32

// architectural registers, r0 reads as zero
`define OOO_NREG 8
`define OOO_REG_AW $clog2(`OOO_NREG)

// words in the data memory model
`define OOO_MEM_WORDS 64

`endif

// File: src/ooo_pkg.sv
`include "ooo_cfg.svh"

package ooo_pkg;

    typedef logic [`OOO_XLEN-1:0] word_t;
    typedef logic [`OOO_REG_AW-1:0] reg_addr_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI,
        OP_LW,
        OP_SW
    } op_e;

    // TAG_NONE means the value is already present
    typedef enum logic [1:0] {
        TAG_NONE,
        TAG_ALU0,
        TAG_ALU1,
        TAG_LS
    } tag_e;

    typedef struct packed {
        op_e       op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
    } inst_t;

    typedef struct packed {
        logic  valid;
        tag_e  tag;
        word_t data;
    } cdb_t;

    // one operand as held by a station or the register file
    typedef struct packed {
        tag_e  tag;
        word_t data;
    } opnd_t;

    typedef struct packed {
        op_e       op;
        word_t     imm;
        tag_e      tag_x;
        tag_e      tag_y;
        word_t     data_x;
        word_t     data_y;
        reg_addr_t rd;
    } rs_entry_t;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        word_t paddr;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        logic  pready;
        word_t prdata;
        logic  pslverr;
    } apb_rsp_t;

    function automatic logic cdb_hit(input cdb_t c, input tag_e t);
        return c.valid && t != TAG_NONE && c.tag == t;
    endfunction

    // capture a broadcast value if the operand waits on that bus
    function automatic opnd_t snoop(input tag_e tag, input word_t data,
                                    input cdb_t c0, input cdb_t c1, input cdb_t c2);
        opnd_t o;
        o.tag  = tag;
        o.data = data;
        if (cdb_hit(c0, tag)) begin
            o = '{tag: TAG_NONE, data: c0.data};
        end else if (cdb_hit(c1, tag)) begin
            o = '{tag: TAG_NONE, data: c1.data};
        end else if (cdb_hit(c2, tag)) begin
            o = '{tag: TAG_NONE, data: c2.data};
        end
        return o;
    endfunction

endpackage

// File: src/reg_status.sv
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module reg_status (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  ooo_pkg::reg_addr_t rs1_addr,
    input  ooo_pkg::reg_addr_t rs2_addr,
    output ooo_pkg::tag_e      rs1_tag,
    output ooo_pkg::tag_e      rs2_tag,
    output ooo_pkg::word_t     rs1_data,
    output ooo_pkg::word_t     rs2_data,
    input  logic               alloc_en,
    input  ooo_pkg::reg_addr_t alloc_rd,
    input  ooo_pkg::tag_e      alloc_tag,
    input  ooo_pkg::cdb_t      cdb0,
    input  ooo_pkg::cdb_t      cdb1,
    input  ooo_pkg::cdb_t      cdb_ls
);

    ooo_pkg::word_t regs [`OOO_NREG];
    ooo_pkg::tag_e  owner [`OOO_NREG];
    ooo_pkg::opnd_t ret [`OOO_NREG];    // value after this cycle's broadcasts
    ooo_pkg::opnd_t src1;
    ooo_pkg::opnd_t src2;

    always_comb begin
        ret[0] = '{tag: ooo_pkg::TAG_NONE, data: '0};  // r0 stays zero
        for (int i = 1; i < `OOO_NREG; i++) begin
            ret[i] = ooo_pkg::snoop(owner[i], regs[i], cdb0, cdb1, cdb_ls);
        end
    end

    // lookups see a same-cycle broadcast as a ready value
    always_comb begin
        src1 = ret[rs1_addr];
        src2 = ret[rs2_addr];
    end

    assign rs1_tag  = src1.tag;
    assign rs1_data = src1.data;
    assign rs2_tag  = src2.tag;
    assign rs2_data = src2.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `OOO_NREG; i++) begin
                regs[i]  <= '0;
                owner[i] <= ooo_pkg::TAG_NONE;
            end
        end else if (rdy) begin
            for (int i = 0; i < `OOO_NREG; i++) begin
                regs[i]  <= ret[i].data;
                owner[i] <= ret[i].tag;
                if (alloc_en && alloc_rd == ooo_pkg::reg_addr_t'(i)) begin
                    owner[i] <= alloc_tag;  // newer producer wins over retire
                end
            end
        end
    end

endmodule

// File: src/dispatch.sv
`timescale 1ns/1ps

module dispatch (
    input  ooo_pkg::inst_t     inst,
    input  logic               inst_valid,
    output logic               inst_ready,
    input  logic               rdy,
    output ooo_pkg::reg_addr_t rs1_addr,
    output ooo_pkg::reg_addr_t rs2_addr,
    input  ooo_pkg::tag_e      rs1_tag,
    input  ooo_pkg::tag_e      rs2_tag,
    input  ooo_pkg::word_t     rs1_data,
    input  ooo_pkg::word_t     rs2_data,
    output logic               alloc_en,
    output ooo_pkg::reg_addr_t alloc_rd,
    output ooo_pkg::tag_e      alloc_tag,
    input  logic               busy_alu0,
    input  logic               busy_alu1,
    input  logic               busy_ls,
    output logic               alloc_alu0,
    output logic               alloc_alu1,
    output logic               alloc_ls,
    output ooo_pkg::rs_entry_t entry
);

    logic is_mem;
    logic use_rs2;
    logic accept;

    always_comb begin
        is_mem  = inst.op == ooo_pkg::OP_LW || inst.op == ooo_pkg::OP_SW;
        use_rs2 = !(inst.op == ooo_pkg::OP_ADDI || inst.op == ooo_pkg::OP_LW);

        inst_ready = rdy && (is_mem ? !busy_ls : (!busy_alu0 || !busy_alu1));
        accept     = inst_valid && inst_ready;

        alloc_ls   = accept && is_mem;
        alloc_alu0 = accept && !is_mem && !busy_alu0;  // alu0 first
        alloc_alu1 = accept && !is_mem && busy_alu0;

        if (is_mem) begin
            alloc_tag = ooo_pkg::TAG_LS;
        end else if (!busy_alu0) begin
            alloc_tag = ooo_pkg::TAG_ALU0;
        end else begin
            alloc_tag = ooo_pkg::TAG_ALU1;
        end
        alloc_rd = inst.rd;
        alloc_en = accept && inst.rd != '0 && inst.op != ooo_pkg::OP_SW;
    end

    assign rs1_addr = inst.rs1;
    assign rs2_addr = inst.rs2;

    always_comb begin
        entry.op     = inst.op;
        entry.imm    = inst.imm;
        entry.tag_x  = rs1_tag;
        entry.data_x = rs1_data;
        entry.tag_y  = use_rs2 ? rs2_tag : ooo_pkg::TAG_NONE;   // y unused by addi/lw
        entry.data_y = rs2_data;
        entry.rd     = inst.rd;
    end

endmodule

// File: src/rs_alu.sv
`timescale 1ns/1ps

module rs_alu #(
    parameter ooo_pkg::tag_e RS_TAG = ooo_pkg::TAG_ALU0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               alloc,
    input  ooo_pkg::rs_entry_t entry,
    input  ooo_pkg::cdb_t      cdb0,
    input  ooo_pkg::cdb_t      cdb1,
    input  ooo_pkg::cdb_t      cdb_ls,
    input  logic               unit_idle,
    output logic               busy,
    output logic               issue,
    output ooo_pkg::rs_entry_t issued
);

    ooo_pkg::rs_entry_t ent;
    ooo_pkg::rs_entry_t src;
    ooo_pkg::opnd_t     nx;
    ooo_pkg::opnd_t     ny;
    logic               fire;

    always_comb begin
        src  = alloc ? entry : ent;     // snoop the new entry too
        nx   = ooo_pkg::snoop(src.tag_x, src.data_x, cdb0, cdb1, cdb_ls);
        ny   = ooo_pkg::snoop(src.tag_y, src.data_y, cdb0, cdb1, cdb_ls);
        fire = ooo_pkg::cdb_hit(cdb0, RS_TAG) || ooo_pkg::cdb_hit(cdb1, RS_TAG)
            || ooo_pkg::cdb_hit(cdb_ls, RS_TAG);
    end

    // unit goes busy on the issue edge, so this pulses once
    assign issue = rdy && busy && unit_idle
                && ent.tag_x == ooo_pkg::TAG_NONE && ent.tag_y == ooo_pkg::TAG_NONE;
    assign issued = ent;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            ent.tag_x <= ooo_pkg::TAG_NONE;
            ent.tag_y <= ooo_pkg::TAG_NONE;
        end else if (rdy) begin
            if (alloc) begin
                busy <= 1'b1;
            end else if (fire) begin
                busy <= 1'b0;   // own result went out
            end
            if (alloc || busy) begin
                ent        <= src;
                ent.tag_x  <= nx.tag;
                ent.data_x <= nx.data;
                ent.tag_y  <= ny.tag;
                ent.data_y <= ny.data;
            end
        end
    end

endmodule

// File: src/rs_ls.sv
`timescale 1ns/1ps

module rs_ls (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               alloc,
    input  ooo_pkg::rs_entry_t entry,
    input  ooo_pkg::cdb_t      cdb0,
    input  ooo_pkg::cdb_t      cdb1,
    input  ooo_pkg::cdb_t      cdb_ls,
    input  logic               unit_idle,
    input  logic               ls_done,
    output logic               busy,
    output logic               issue,
    output ooo_pkg::rs_entry_t issued
);

    ooo_pkg::rs_entry_t ent;
    ooo_pkg::rs_entry_t src;
    ooo_pkg::opnd_t     nx;
    ooo_pkg::opnd_t     ny;
    logic               finish;

    always_comb begin
        src = alloc ? entry : ent;
        nx  = ooo_pkg::snoop(src.tag_x, src.data_x, cdb0, cdb1, cdb_ls);
        ny  = ooo_pkg::snoop(src.tag_y, src.data_y, cdb0, cdb1, cdb_ls);
        // loads end on their bus pulse, stores only on done
        finish = ls_done || ooo_pkg::cdb_hit(cdb_ls, ooo_pkg::TAG_LS);
    end

    // base in x, store data in y, both needed before the address goes out
    assign issue = rdy && busy && unit_idle
                && ent.tag_x == ooo_pkg::TAG_NONE && ent.tag_y == ooo_pkg::TAG_NONE;
    assign issued = ent;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            ent.tag_x <= ooo_pkg::TAG_NONE;
            ent.tag_y <= ooo_pkg::TAG_NONE;
        end else if (rdy) begin
            if (alloc) begin
                busy       <= 1'b1;
                ent        <= src;
                ent.tag_x  <= nx.tag;
                ent.data_x <= nx.data;
                ent.tag_y  <= ny.tag;
                ent.data_y <= ny.data;
            end else if (busy) begin
                busy       <= !finish;
                ent.tag_x  <= nx.tag;
                ent.data_x <= nx.data;
                ent.tag_y  <= ny.tag;
                ent.data_y <= ny.data;
            end
        end
    end

endmodule

// File: src/alu_exec.sv
`timescale 1ns/1ps

module alu_exec (
    input  logic           clk,
    input  logic           rst,
    input  logic           rdy,
    input  logic           issue,
    input  ooo_pkg::op_e   op,
    input  ooo_pkg::word_t a,
    input  ooo_pkg::word_t b,
    input  ooo_pkg::word_t imm,
    input  ooo_pkg::tag_e  tag,
    output logic           idle,
    output ooo_pkg::cdb_t  cdb
);

    ooo_pkg::word_t res;
    ooo_pkg::word_t res_q;
    ooo_pkg::tag_e  tag_q;
    logic           valid_q;

    always_comb begin
        case (op)
            ooo_pkg::OP_SUB:  res = a - b;
            ooo_pkg::OP_AND:  res = a & b;
            ooo_pkg::OP_OR:   res = a | b;
            ooo_pkg::OP_XOR:  res = a ^ b;
            ooo_pkg::OP_ADDI: res = a + imm;
            default:          res = a + b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (rdy) begin
            valid_q <= issue;   // one-cycle pulse
            if (issue) begin
                res_q <= res;
                tag_q <= tag;
            end
        end
    end

    assign cdb  = '{valid: valid_q, tag: tag_q, data: res_q};
    assign idle = !valid_q;

endmodule

// File: src/ls_exec.sv
`timescale 1ns/1ps

module ls_exec (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               issue,
    input  ooo_pkg::rs_entry_t entry,
    output ooo_pkg::apb_req_t  apb_req,
    input  ooo_pkg::apb_rsp_t  apb_rsp,
    output logic               idle,
    output logic               done,
    output ooo_pkg::cdb_t      cdb
);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } state_e;

    state_e         state;
    ooo_pkg::word_t paddr_q;
    ooo_pkg::word_t pwdata_q;
    logic           pwrite_q;
    logic           ld_valid;
    ooo_pkg::word_t ld_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            done     <= 1'b0;
            ld_valid <= 1'b0;
        end else begin
            // completion pulse is held until a rdy cycle sees it
            if (rdy) begin
                done     <= 1'b0;
                ld_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (issue) begin
                        state    <= SETUP;
                        paddr_q  <= entry.data_x + entry.imm;
                        pwdata_q <= entry.data_y;
                        pwrite_q <= entry.op == ooo_pkg::OP_SW;
                    end
                end
                SETUP: state <= ACCESS;
                ACCESS: begin
                    if (apb_rsp.pready) begin
                        state    <= IDLE;
                        done     <= 1'b1;
                        ld_valid <= !pwrite_q;
                        ld_data  <= apb_rsp.pslverr ? '0 : apb_rsp.prdata;  // bad read gives 0
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        apb_req.psel    = state != IDLE;
        apb_req.penable = state == ACCESS;
        apb_req.pwrite  = pwrite_q;
        apb_req.paddr   = paddr_q;
        apb_req.pwdata  = pwdata_q;
    end

    assign idle = state == IDLE && !done;
    assign cdb  = '{valid: ld_valid, tag: ooo_pkg::TAG_LS, data: ld_data};

endmodule

// File: src/ooo_core.sv
`timescale 1ns/1ps

module ooo_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  ooo_pkg::inst_t    inst,
    input  logic              inst_valid,
    output logic              inst_ready,
    output ooo_pkg::apb_req_t apb_req,
    input  ooo_pkg::apb_rsp_t apb_rsp
);

    ooo_pkg::reg_addr_t rs1_addr, rs2_addr, alloc_rd;
    ooo_pkg::tag_e      rs1_tag, rs2_tag, alloc_tag;
    ooo_pkg::word_t     rs1_data, rs2_data;
    ooo_pkg::rs_entry_t entry, alu0_entry, alu1_entry, ls_entry;
    ooo_pkg::cdb_t      cdb0, cdb1, cdb_ls;
    logic               alloc_en, alloc_alu0, alloc_alu1, alloc_ls;
    logic               busy_alu0, busy_alu1, busy_ls;
    logic               issue_alu0, issue_alu1, issue_ls;
    logic               idle_alu0, idle_alu1, idle_ls, ls_done;
    logic               run;

    // keeps inst_ready low for the first cycle out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    reg_status reg_status_i (
        .clk, .rst, .rdy, .rs1_addr, .rs2_addr, .rs1_tag, .rs2_tag, .rs1_data, .rs2_data,
        .alloc_en, .alloc_rd, .alloc_tag, .cdb0, .cdb1, .cdb_ls
    );

    dispatch dispatch_i (
        .inst, .inst_valid, .inst_ready, .rdy(rdy && run),
        .rs1_addr, .rs2_addr, .rs1_tag, .rs2_tag, .rs1_data, .rs2_data,
        .alloc_en, .alloc_rd, .alloc_tag, .busy_alu0, .busy_alu1, .busy_ls,
        .alloc_alu0, .alloc_alu1, .alloc_ls, .entry
    );

    rs_alu #(.RS_TAG(ooo_pkg::TAG_ALU0)) alu0_rs_i (
        .clk, .rst, .rdy, .alloc(alloc_alu0), .entry, .cdb0, .cdb1, .cdb_ls,
        .unit_idle(idle_alu0), .busy(busy_alu0), .issue(issue_alu0), .issued(alu0_entry)
    );

    rs_alu #(.RS_TAG(ooo_pkg::TAG_ALU1)) alu1_rs_i (
        .clk, .rst, .rdy, .alloc(alloc_alu1), .entry, .cdb0, .cdb1, .cdb_ls,
        .unit_idle(idle_alu1), .busy(busy_alu1), .issue(issue_alu1), .issued(alu1_entry)
    );

    alu_exec alu0_exec_i (
        .clk, .rst, .rdy, .issue(issue_alu0), .op(alu0_entry.op),
        .a(alu0_entry.data_x), .b(alu0_entry.data_y), .imm(alu0_entry.imm),
        .tag(ooo_pkg::TAG_ALU0), .idle(idle_alu0), .cdb(cdb0)
    );

    alu_exec alu1_exec_i (
        .clk, .rst, .rdy, .issue(issue_alu1), .op(alu1_entry.op),
        .a(alu1_entry.data_x), .b(alu1_entry.data_y), .imm(alu1_entry.imm),
        .tag(ooo_pkg::TAG_ALU1), .idle(idle_alu1), .cdb(cdb1)
    );

    rs_ls ls_rs_i (
        .clk, .rst, .rdy, .alloc(alloc_ls), .entry, .cdb0, .cdb1, .cdb_ls,
        .unit_idle(idle_ls), .ls_done, .busy(busy_ls), .issue(issue_ls), .issued(ls_entry)
    );

    ls_exec ls_exec_i (
        .clk, .rst, .rdy, .issue(issue_ls), .entry(ls_entry), .apb_req, .apb_rsp,
        .idle(idle_ls), .done(ls_done), .cdb(cdb_ls)
    );

endmodule

// File: sim/apb_mem.sv
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module apb_mem (
    input  logic              clk,
    input  logic              rst,
    input  ooo_pkg::apb_req_t req,
    output ooo_pkg::apb_rsp_t rsp
);

    ooo_pkg::word_t mem [`OOO_MEM_WORDS];
    logic [1:0]     wait_cnt;
    int             seed = 32'h90b246d6;
    int             idx;

    always_comb begin
        idx         = int'(req.paddr >> 2) % `OOO_MEM_WORDS;  // word addressed
        rsp.pready  = req.psel && req.penable && wait_cnt == 2'd0;
        rsp.prdata  = mem[idx];
        rsp.pslverr = 1'b0;
    end

    always @(posedge clk) begin
        if (rst) begin
            wait_cnt <= 2'd0;
        end else if (req.psel && !req.penable) begin
            wait_cnt <= 2'($random(seed));  // 0 to 3 wait states
        end else if (req.psel && req.penable && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
        if (!rst && rsp.pready && req.pwrite) begin
            mem[idx] <= req.pwdata;
        end
    end

    task automatic mem_preload(input int i, input ooo_pkg::word_t value);
        mem[i] <= value;
    endtask

    function automatic ooo_pkg::word_t mem_peek(input int i);
        return mem[i];
    endfunction

endmodule

// File: sim/ooo_core_assert.sv
`timescale 1ns/1ps

module ooo_core_assert (
    input logic              clk,
    input logic              rst,
    input ooo_pkg::inst_t    inst,
    input logic              inst_valid,
    input logic              inst_ready,
    input ooo_pkg::apb_req_t apb_req,
    input ooo_pkg::apb_rsp_t apb_rsp
);

    int fail_count = 0;     // failed checks so far

    // outputs quiet through reset and the cycle after
    reset_quiet: assert property (@(posedge clk)
        rst |=> !inst_ready && !apb_req.psel && !apb_req.penable)
        else begin
            fail_count++;
            $error("inst_ready or an APB select was active during or right after reset");
        end

    apb_hold: assert property (@(posedge clk) disable iff (rst)
        apb_req.psel && !(apb_req.penable && apb_rsp.pready)
        |=> $stable(apb_req.paddr) && $stable(apb_req.pwrite) && $stable(apb_req.pwdata))
        else begin
            fail_count++;
            $error("APB address, direction or write data changed before the transfer ended");
        end

    // access phase always follows one setup cycle
    enable_after_select: assert property (@(posedge clk) disable iff (rst)
        $rose(apb_req.penable) |-> $past(apb_req.psel) && apb_req.psel)
        else begin
            fail_count++;
            $error("penable rose without psel held in the cycle before");
        end

    select_then_enable: assert property (@(posedge clk) disable iff (rst)
        $rose(apb_req.psel) |=> apb_req.penable)
        else begin
            fail_count++;
            $error("penable did not follow one cycle after psel");
        end

    inst_hold: assert property (@(posedge clk) disable iff (rst)
        inst_valid && !inst_ready |=> $stable(inst))
        else begin
            fail_count++;
            $error("instruction changed while waiting for inst_ready");
        end

endmodule

// File: sim/ooo_core_tb.sv
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module ooo_core_tb;

    logic              clk;
    logic              rst;
    logic              rdy = 1'b1;
    ooo_pkg::inst_t    inst;
    logic              inst_valid;
    logic              inst_ready;
    ooo_pkg::apb_req_t apb_req;
    ooo_pkg::apb_rsp_t apb_rsp;

    ooo_pkg::inst_t    prog [$];
    ooo_pkg::word_t    regs_m [`OOO_NREG];      // program-order register model
    ooo_pkg::word_t    mem_m [`OOO_MEM_WORDS];
    int                seed = 32'h90b246d6;
    int                prog_len = 0;
    int                stall_at = 0;
    int                n_stores = 0;
    int                n_writes = 0;
    logic              stall_en = 1'b0;

    ooo_core dut_i (
        .clk, .rst, .rdy, .inst, .inst_valid, .inst_ready, .apb_req, .apb_rsp
    );

    apb_mem mem_i (.clk, .rst, .req(apb_req), .rsp(apb_rsp));

    bind ooo_core ooo_core_assert assert_i (
        .clk, .rst, .inst, .inst_valid, .inst_ready, .apb_req, .apb_rsp
    );

    always #4 clk = ~clk;

    function automatic int word_index(input ooo_pkg::word_t a);
        return int'(a >> 2) % `OOO_MEM_WORDS;
    endfunction

    function automatic ooo_pkg::word_t fill_word(input int i);
        return ooo_pkg::word_t'(i) * 32'h9e37_79b9 + 32'h0135_7000;
    endfunction

    // append one instruction and run it on the model
    task automatic push_inst(input ooo_pkg::op_e op, input int rd, input int rs1,
                             input int rs2, input ooo_pkg::word_t imm);
        ooo_pkg::inst_t in;
        ooo_pkg::word_t a;
        ooo_pkg::word_t b;
        ooo_pkg::word_t v;
        in.op  = op;
        in.rd  = ooo_pkg::reg_addr_t'(rd);
        in.rs1 = ooo_pkg::reg_addr_t'(rs1);
        in.rs2 = ooo_pkg::reg_addr_t'(rs2);
        in.imm = imm;
        prog.push_back(in);
        a = regs_m[in.rs1];
        b = regs_m[in.rs2];
        v = '0;
        case (op)
            ooo_pkg::OP_ADD:  v = a + b;
            ooo_pkg::OP_SUB:  v = a - b;
            ooo_pkg::OP_AND:  v = a & b;
            ooo_pkg::OP_OR:   v = a | b;
            ooo_pkg::OP_XOR:  v = a ^ b;
            ooo_pkg::OP_ADDI: v = a + imm;
            ooo_pkg::OP_LW:   v = mem_m[word_index(a + imm)];
            default: begin
                mem_m[word_index(a + imm)] = b;
                n_stores++;
            end
        endcase
        if (op != ooo_pkg::OP_SW && in.rd != '0) begin
            regs_m[in.rd] = v;    // r0 stays zero
        end
    endtask

    task automatic add_random_ops(input int count);
        logic [31:0]    r;
        ooo_pkg::op_e   op;
        ooo_pkg::word_t imm;
        int             rs1;
        for (int k = 0; k < count; k++) begin
            r   = $random(seed);
            op  = ooo_pkg::op_e'(r[2:0]);
            rs1 = int'(r[8:6]);
            imm = $random(seed);
            if (op == ooo_pkg::OP_LW || op == ooo_pkg::OP_SW) begin
                rs1 = 0;
                imm = {24'h0, r[17:12], 2'b00};   // word aligned inside the memory
            end
            push_inst(op, int'(r[5:3]), rs1, int'(r[11:9]), imm);
        end
    endtask

    task automatic build_program();
        // independent ops on loaded and immediate values
        push_inst(ooo_pkg::OP_LW,   1, 0, 0, 32'h0);
        push_inst(ooo_pkg::OP_LW,   2, 0, 0, 32'h4);
        push_inst(ooo_pkg::OP_ADDI, 3, 0, 0, 32'h0000_1234);
        push_inst(ooo_pkg::OP_ADDI, 4, 0, 0, 32'hffff_fff0);
        push_inst(ooo_pkg::OP_ADD,  5, 1, 2, '0);
        push_inst(ooo_pkg::OP_SUB,  6, 3, 4, '0);
        push_inst(ooo_pkg::OP_AND,  7, 1, 3, '0);
        push_inst(ooo_pkg::OP_SW,   0, 0, 5, 32'h80);
        push_inst(ooo_pkg::OP_SW,   0, 0, 6, 32'ha4);
        push_inst(ooo_pkg::OP_OR,   5, 2, 4, '0);
        push_inst(ooo_pkg::OP_XOR,  6, 1, 4, '0);
        push_inst(ooo_pkg::OP_SW,   0, 0, 6, 32'h84);
        push_inst(ooo_pkg::OP_SW,   0, 0, 7, 32'h88);
        push_inst(ooo_pkg::OP_SW,   0, 0, 5, 32'h8c);
        // dependent chains with two sources on different stations
        push_inst(ooo_pkg::OP_ADDI, 1, 1, 0, 32'h5);
        push_inst(ooo_pkg::OP_ADD,  2, 1, 1, '0);
        push_inst(ooo_pkg::OP_SUB,  3, 2, 1, '0);
        push_inst(ooo_pkg::OP_ADD,  4, 2, 3, '0);
        push_inst(ooo_pkg::OP_XOR,  1, 4, 3, '0);
        push_inst(ooo_pkg::OP_SW,   0, 0, 4, 32'h90);
        push_inst(ooo_pkg::OP_SW,   0, 0, 1, 32'h94);
        // write, read, write again to r5
        push_inst(ooo_pkg::OP_ADDI, 5, 0, 0, 32'h111);
        push_inst(ooo_pkg::OP_ADD,  6, 5, 0, '0);
        push_inst(ooo_pkg::OP_ADDI, 5, 0, 0, 32'h222);
        push_inst(ooo_pkg::OP_SW,   0, 0, 6, 32'h98);
        push_inst(ooo_pkg::OP_SW,   0, 0, 5, 32'h9c);
        // store then load back through a computed base
        push_inst(ooo_pkg::OP_ADDI, 7, 0, 0, 32'h60);
        push_inst(ooo_pkg::OP_SW,   0, 7, 3, 32'h8);
        push_inst(ooo_pkg::OP_LW,   2, 7, 0, 32'h8);
        push_inst(ooo_pkg::OP_ADD,  2, 2, 2, '0);
        push_inst(ooo_pkg::OP_SW,   0, 0, 2, 32'ha0);
        // memory burst against the single load/store station
        push_inst(ooo_pkg::OP_SW,   0, 0, 1, 32'hb0);
        push_inst(ooo_pkg::OP_LW,   3, 0, 0, 32'hb0);
        push_inst(ooo_pkg::OP_SW,   0, 0, 3, 32'hb4);
        push_inst(ooo_pkg::OP_LW,   4, 0, 0, 32'h8);
        push_inst(ooo_pkg::OP_SW,   0, 0, 4, 32'hb8);
        push_inst(ooo_pkg::OP_LW,   6, 0, 0, 32'hb4);
        stall_at = prog.size();
        add_random_ops(48);
        for (int r = 1; r < `OOO_NREG; r++) begin
            push_inst(ooo_pkg::OP_SW, 0, 0, r, ooo_pkg::word_t'(32'he0 + 4 * r));
        end
    endtask

    always @(posedge clk) begin
        if (stall_en) begin
            rdy <= 2'($random(seed)) != 2'd0;   // high about three cycles in four
        end else begin
            rdy <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst && apb_rsp.pready && apb_req.pwrite) begin
            n_writes <= n_writes + 1;
        end
    end

    always @(posedge clk) begin
        if (dut_i.assert_i.fail_count != 0) begin
            $display("Test failed");
            $fatal(1, "a protocol assertion on the core failed");
        end
    end

    initial begin
        wait (prog_len != 0);
        repeat (prog_len * 40 + 200) @(posedge clk);
        $display("timeout: program did not finish within %0d cycles", prog_len * 40 + 200);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        ooo_pkg::word_t got;
        clk        = 1'b0;
        rst        = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        for (int i = 0; i < `OOO_NREG; i++) begin
            regs_m[i] = '0;
        end
        for (int i = 0; i < `OOO_MEM_WORDS; i++) begin
            mem_m[i] = fill_word(i);
            mem_i.mem_preload(i, mem_m[i]);
        end
        build_program();
        prog_len = prog.size();

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        foreach (prog[i]) begin
            if (i == stall_at) begin
                stall_en <= 1'b1;
            end
            inst       <= prog[i];
            inst_valid <= 1'b1;
            @(posedge clk);
            while (!inst_ready) begin
                @(posedge clk);
            end
        end
        inst_valid <= 1'b0;

        // stores leave in program order, so the last write ends the program
        while (n_writes < n_stores) begin
            @(posedge clk);
        end
        stall_en <= 1'b0;
        repeat (2) @(posedge clk);

        for (int a = 0; a < `OOO_MEM_WORDS; a++) begin
            got = mem_i.mem_peek(a);
            assert (got == mem_m[a]) else begin
                $display("[FAIL] mem[%0d] expected %h actual %h", a, mem_m[a], got);
                $display("Test failed");
                $fatal(1, "memory contents differ from the program-order model");
            end
        end

        if (dut_i.assert_i.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "protocol assertions failed during the run");
        end
    end

endmodule

// File: ooo_core.f
+incdir+src
src/ooo_pkg.sv
src/reg_status.sv
src/dispatch.sv
src/rs_alu.sv
src/rs_ls.sv
src/alu_exec.sv
src/ls_exec.sv
src/ooo_core.sv
sim/apb_mem.sv
sim/ooo_core_assert.sv
sim/ooo_core_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := ooo_core_tb
FLIST    := ooo_core.f
OBJ_DIR  := obj_dir
RUN_ARGS := +verilator+error+limit+100
PASS_MSG := Test passed

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv src/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
